/* source/game_pkg.sv */
package game_pkg;

	// the field is square, rows count down from the top
	localparam int GRID_CELLS = 5;
	localparam int LAST_CELL = GRID_CELLS - 1;

	// column or row index
	typedef logic [2:0] cell_t;

	// one decimal digit of the score
	typedef logic [3:0] bcd_t;

	// bit row*GRID_CELLS+col is set for a live block
	typedef logic [GRID_CELLS*GRID_CELLS-1:0] cell_map_t;

	localparam cell_t PLAYER_START_COL = 3'd2; // middle lane
	localparam cell_t PLAYER_START_ROW = 3'd4; // bottom row

	localparam logic [3:0] LANE_SEED = 4'b1001; // any nonzero value keeps the LFSR alive

endpackage

/* source/step_timer.sv */
module step_timer #(
	parameter int STEP_CYCLES = 16
) (
	input logic clock,
	input logic reset,
	input logic run,
	input logic clear,
	input logic score_inc,
	output logic tick,
	output game_pkg::bcd_t score_tens,
	output game_pkg::bcd_t score_ones
);

	localparam int COUNT_W = $clog2(STEP_CYCLES);

	logic [COUNT_W-1:0] count;
	logic at_max;

	// first RUN cycle sees zero and loads, so the count reaches one in the last cycle
	always_ff @(posedge clock)
	begin
		if (!reset || !run)
			count <= '0;
		else if (count == '0)
			count <= COUNT_W'(STEP_CYCLES - 1);
		else
			count <= count - 1'b1;
	end

	assign tick = run && (count == COUNT_W'(1));

	assign at_max = (score_tens == 4'd9) && (score_ones == 4'd9); // score stops at 99

	always_ff @(posedge clock)
	begin
		if (!reset || clear)
		begin
			score_tens <= '0;
			score_ones <= '0;
		end
		else if (score_inc && !at_max)
		begin
			if (score_ones == 4'd9)
			begin
				score_ones <= '0;
				score_tens <= score_tens + 1'b1; // carry into the tens digit
			end
			else
				score_ones <= score_ones + 1'b1;
		end
	end

endmodule

/* source/game_fsm.sv */
module game_fsm (
	input logic clock,
	input logic reset,
	input logic go,
	input logic tick,
	input logic hit,
	output logic run,
	output logic clear,
	output logic advance,
	output logic spawn,
	output logic score_inc,
	output logic playing,
	output logic game_over
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		RUN,
		MOVE,
		SPAWN,
		CHECK,
		OVER
	} game_state_t;

	game_state_t state;
	game_state_t next_state;

	always_ff @(posedge clock)
	begin
		if (!reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	// a step is the fixed sequence MOVE, SPAWN, CHECK after each tick
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (go)
					next_state = START;
			START:
				next_state = RUN;
			RUN:
				if (tick)
					next_state = MOVE;
			MOVE:
				next_state = SPAWN;
			SPAWN:
				next_state = CHECK;
			CHECK:
				next_state = hit ? OVER : RUN;
			OVER:
				if (go)
					next_state = START; // everything holds until the player restarts
			default:
				next_state = IDLE;
		endcase
	end

	assign run = (state == RUN);
	assign clear = (state == START);
	assign advance = (state == MOVE);
	assign spawn = (state == SPAWN);
	assign score_inc = (state == CHECK) && !hit; // only a survived step counts
	assign playing = state inside {START, RUN, MOVE, SPAWN, CHECK};
	assign game_over = (state == OVER);

endmodule

/* source/lane_random.sv */
module lane_random (
	input logic clock,
	input logic reset,
	input logic spawn,
	output game_pkg::cell_t lane
);

	logic [3:0] lfsr;

	// not cleared between games so each game gets a fresh lane sequence
	always_ff @(posedge clock)
	begin
		if (!reset)
			lfsr <= game_pkg::LANE_SEED;
		else if (spawn)
			lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
	end

	// the lane in use during SPAWN is the value before the shift
	assign lane = game_pkg::cell_t'(lfsr % game_pkg::GRID_CELLS);

endmodule

/* source/player_cell.sv */
module player_cell (
	input logic clock,
	input logic reset,
	input logic clear,
	input logic advance,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	output game_pkg::cell_t player_col,
	output game_pkg::cell_t player_row
);

	always_ff @(posedge clock)
	begin
		if (!reset || clear)
		begin
			player_col <= game_pkg::PLAYER_START_COL;
			player_row <= game_pkg::PLAYER_START_ROW;
		end
		else if (advance)
		begin
			// left wins over right when both are pressed, even at the left edge
			if (left)
			begin
				if (player_col != '0)
					player_col <= player_col - 1'b1;
			end
			else if (right && player_col != game_pkg::cell_t'(game_pkg::LAST_CELL))
				player_col <= player_col + 1'b1;

			// up wins over down in the same way
			if (up)
			begin
				if (player_row != '0)
					player_row <= player_row - 1'b1;
			end
			else if (down && player_row != game_pkg::cell_t'(game_pkg::LAST_CELL))
				player_row <= player_row + 1'b1;
		end
	end

endmodule

/* source/block_field.sv */
module block_field #(
	parameter int NUM_BLOCKS = 5
) (
	input logic clock,
	input logic reset,
	input logic clear,
	input logic advance,
	input logic spawn,
	input game_pkg::cell_t lane,
	input game_pkg::cell_t player_col,
	input game_pkg::cell_t player_row,
	output logic hit,
	output game_pkg::cell_map_t cell_map
);

	localparam int PTR_W = (NUM_BLOCKS > 1) ? $clog2(NUM_BLOCKS) : 1;

	logic [NUM_BLOCKS-1:0] valid;
	game_pkg::cell_t slot_col [NUM_BLOCKS];
	game_pkg::cell_t slot_row [NUM_BLOCKS];
	logic [PTR_W-1:0] ptr;

	always_ff @(posedge clock)
	begin
		if (!reset || clear)
		begin
			valid <= '0;
			ptr <= '0;
		end
		else
		begin
			if (advance)
			begin
				for (int i = 0; i < NUM_BLOCKS; i++)
				begin
					if (valid[i] && slot_row[i] == game_pkg::cell_t'(game_pkg::LAST_CELL))
						valid[i] <= 1'b0; // falls out below the bottom row
				end
			end
			if (spawn)
			begin
				valid[ptr] <= 1'b1; // oldest slot is reused when all are live
				if (ptr == PTR_W'(NUM_BLOCKS - 1))
					ptr <= '0;
				else
					ptr <= ptr + 1'b1;
			end
		end
	end

	// positions only mean something while the slot is valid
	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			for (int i = 0; i < NUM_BLOCKS; i++)
			begin
				if (valid[i])
					slot_row[i] <= slot_row[i] + 1'b1;
			end
		end
		if (spawn)
		begin
			slot_col[ptr] <= lane;
			slot_row[ptr] <= '0;
		end
	end

	always_comb
	begin
		hit = 1'b0;
		cell_map = '0;
		for (int i = 0; i < NUM_BLOCKS; i++)
		begin
			if (valid[i])
			begin
				cell_map[slot_row[i] * game_pkg::GRID_CELLS + slot_col[i]] = 1'b1;
				if (slot_col[i] == player_col && slot_row[i] == player_row)
					hit = 1'b1;
			end
		end
	end

endmodule

/* source/dodge_top.sv */
module dodge_top #(
	parameter int STEP_CYCLES = 16,
	parameter int NUM_BLOCKS = 5
) (
	input logic clock,
	input logic reset,
	input logic go,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	output logic playing,
	output logic game_over,
	output game_pkg::cell_t player_col,
	output game_pkg::cell_t player_row,
	output game_pkg::bcd_t score_tens,
	output game_pkg::bcd_t score_ones,
	output game_pkg::cell_map_t cell_map
);

	logic run;
	logic clear;
	logic advance;
	logic spawn;
	logic score_inc;
	logic tick;
	logic hit;
	game_pkg::cell_t lane;

	game_fsm fsm (
		.clock(clock),
		.reset(reset),
		.go(go),
		.tick(tick),
		.hit(hit),
		.run(run),
		.clear(clear),
		.advance(advance),
		.spawn(spawn),
		.score_inc(score_inc),
		.playing(playing),
		.game_over(game_over)
	);

	step_timer #(.STEP_CYCLES(STEP_CYCLES)) timer (
		.clock(clock),
		.reset(reset),
		.run(run),
		.clear(clear),
		.score_inc(score_inc),
		.tick(tick),
		.score_tens(score_tens),
		.score_ones(score_ones)
	);

	lane_random random (
		.clock(clock),
		.reset(reset),
		.spawn(spawn),
		.lane(lane)
	);

	player_cell player (
		.clock(clock),
		.reset(reset),
		.clear(clear),
		.advance(advance),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.player_col(player_col),
		.player_row(player_row)
	);

	block_field #(.NUM_BLOCKS(NUM_BLOCKS)) field (
		.clock(clock),
		.reset(reset),
		.clear(clear),
		.advance(advance),
		.spawn(spawn),
		.lane(lane),
		.player_col(player_col),
		.player_row(player_row),
		.hit(hit),
		.cell_map(cell_map)
	);

endmodule

/* dv/tb_clock.sv */
module tb_clock #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clock = 1'b0;
		forever
			#(PERIOD_NS / 2) clock = ~clock;
	end

	initial
	begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b1; // released just after an edge like the other inputs
	end

endmodule

/* dv/dodge_tb.sv */
module dodge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STEP_CYCLES = 4;
	localparam int STEP_LEN = STEP_CYCLES + 3; // RUN cycles, then MOVE, SPAWN and CHECK
	localparam int SLOTS = 5;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_GAMES = 3;
	localparam int RANDOM_STEPS = 20;
	localparam int HOLD_LIMIT = 30; // a block reaches a still player within 19 steps
	localparam int DODGE_STEPS = 105;
	localparam int START_CYCLES = 3;
	localparam int TOTAL_STEPS = RANDOM_GAMES * (RANDOM_STEPS + HOLD_LIMIT) + DODGE_STEPS;
	localparam int TIMEOUT_CYCLES = (3 * TOTAL_STEPS * STEP_LEN) / 2 + RESET_CYCLES
		+ (RANDOM_GAMES + 1) * (START_CYCLES + STEP_LEN);

	typedef struct packed {
		game_pkg::cell_t col;
		game_pkg::cell_t row;
		logic [SLOTS-1:0] valid;
		game_pkg::cell_t [SLOTS-1:0] scol;
		game_pkg::cell_t [SLOTS-1:0] srow;
		logic [2:0] ptr;
		logic [3:0] lfsr;
		game_pkg::bcd_t tens;
		game_pkg::bcd_t ones;
		logic hit;
	} model_t;

	logic clock;
	logic reset;
	logic go;
	logic left;
	logic right;
	logic up;
	logic down;
	logic playing;
	logic game_over;
	game_pkg::cell_t player_col;
	game_pkg::cell_t player_row;
	game_pkg::bcd_t score_tens;
	game_pkg::bcd_t score_ones;
	game_pkg::cell_map_t cell_map;

	model_t model;
	model_t expect_q[$];
	logic [31:0] rand_state = 32'hcb366cb8;
	logic [7:0] last_score = '0;
	logic last_over = 1'b0;
	logic broken = 1'b0;
	int cycle_count = 0;
	int end_cycle = 0;
	int steps_checked = 0;
	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
		.clock(clock),
		.reset(reset)
	);

	dodge_top #(.STEP_CYCLES(STEP_CYCLES)) UUT (
		.clock(clock),
		.reset(reset),
		.go(go),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.playing(playing),
		.game_over(game_over),
		.player_col(player_col),
		.player_row(player_row),
		.score_tens(score_tens),
		.score_ones(score_ones),
		.cell_map(cell_map)
	);

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	// taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one game step: move, fall, spawn, hit and score
	function automatic model_t model_step(input model_t s, input logic l, input logic r,
		input logic u, input logic d);
		model_t n;
		n = s;
		if (l)
		begin
			if (s.col != 0)
				n.col = s.col - 1'b1;
		end
		else if (r && s.col != game_pkg::LAST_CELL)
			n.col = s.col + 1'b1;
		if (u)
		begin
			if (s.row != 0)
				n.row = s.row - 1'b1;
		end
		else if (d && s.row != game_pkg::LAST_CELL)
			n.row = s.row + 1'b1;
		for (int i = 0; i < SLOTS; i++)
		begin
			if (s.valid[i] && s.srow[i] == game_pkg::LAST_CELL)
				n.valid[i] = 1'b0;
			else if (s.valid[i])
				n.srow[i] = s.srow[i] + 1'b1;
		end
		n.valid[s.ptr] = 1'b1; // the lane comes from the generator before it steps
		n.scol[s.ptr] = game_pkg::cell_t'(s.lfsr % game_pkg::GRID_CELLS);
		n.srow[s.ptr] = '0;
		n.ptr = (s.ptr == SLOTS - 1) ? 3'd0 : s.ptr + 1'b1;
		n.lfsr = {s.lfsr[2:0], s.lfsr[3] ^ s.lfsr[2]};
		n.hit = 1'b0;
		for (int i = 0; i < SLOTS; i++)
		begin
			if (n.valid[i] && n.scol[i] == n.col && n.srow[i] == n.row)
				n.hit = 1'b1;
		end
		if (!n.hit && !(s.tens == 9 && s.ones == 9))
		begin
			n.ones = (s.ones == 9) ? 4'd0 : s.ones + 1'b1;
			n.tens = (s.ones == 9) ? s.tens + 1'b1 : s.tens;
		end
		return n;
	endfunction

	function automatic game_pkg::cell_map_t map_of(input model_t s);
		game_pkg::cell_map_t m;
		m = '0;
		for (int i = 0; i < SLOTS; i++)
		begin
			if (s.valid[i])
				m[s.srow[i] * game_pkg::GRID_CELLS + s.scol[i]] = 1'b1;
		end
		return m;
	endfunction

	// true when a block sits right above the player and falls onto it next step
	function automatic logic block_above(input model_t s);
		logic found;
		found = 1'b0;
		for (int i = 0; i < SLOTS; i++)
		begin
			if (s.valid[i] && s.srow[i] == s.row - 1 && s.scol[i] == s.col)
				found = 1'b1;
		end
		return found;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic print_summary();
		$display("%0d checks, %0d value mismatches, %0d other failures",
			check_count, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
	endtask

	task automatic start_game();
		@(posedge clock);
		#2;
		go = 1'b1;
		@(posedge clock);
		#2;
		go = 1'b0;
		repeat (2) @(negedge clock); // START lasts one cycle, so this is the first RUN cycle
		check_value("playing at start", playing, 1);
		check_value("game_over at start", game_over, 0);
		check_value("score at start", {score_tens, score_ones}, 0);
		check_value("cell_map at start", cell_map, 0);
		check_value("player_col at start", player_col, game_pkg::PLAYER_START_COL);
		check_value("player_row at start", player_row, game_pkg::PLAYER_START_ROW);
		model.col = game_pkg::PLAYER_START_COL;
		model.row = game_pkg::PLAYER_START_ROW;
		model.valid = '0;
		model.ptr = '0;
		model.tens = '0;
		model.ones = '0;
		model.hit = 1'b0; // lfsr carries over from the last game
		last_score = '0;
		last_over = 1'b0;
		end_cycle = cycle_count;
	endtask

	task automatic play_game(input logic dodge, input int random_steps);
		int limit;
		int target;
		logic [3:0] keys;
		limit = dodge ? random_steps : random_steps + HOLD_LIMIT;
		for (int n = 0; n < limit && !model.hit && !broken; n++)
		begin
			@(posedge clock);
			#2;
			keys = 4'b0000;
			if (dodge && block_above(model))
				keys = (model.col == 0) ? 4'b0100 : 4'b1000; // right only from the left edge
			else if (!dodge && n < random_steps)
			begin
				for (int k = 3; k >= 0; k--)
				begin
					rand_state = lfsr_step(rand_state);
					keys[k] = rand_state[0];
				end
			end
			{left, right, up, down} = keys;
			model = model_step(model, keys[3], keys[2], keys[1], keys[0]);
			target = steps_checked + 1;
			expect_q.push_back(model);
			while (steps_checked < target)
				@(negedge clock);
		end
		if (model.hit && !broken)
		begin
			repeat (STEP_LEN) @(negedge clock);
			check_value("game_over held", game_over, 1);
			check_value("playing after hit", playing, 0);
			check_value("frozen score", {score_tens, score_ones}, {model.tens, model.ones});
		end
		else if (!dodge && !broken)
		begin
			other_errors++;
			broken = 1'b1;
			$display("the game did not end within %0d steps of holding still", HOLD_LIMIT);
		end
	endtask

	initial
	begin : compare_steps
		model_t want;
		logic visible;
		logic ended;
		forever
		begin
			@(negedge clock);
			if (expect_q.size() != 0)
			begin
				want = expect_q.pop_front();
				// at 99 a survived step shows nothing, so its end is found by its length
				visible = want.hit || ({want.tens, want.ones} != last_score);
				ended = 1'b0;
				while (!ended && cycle_count <= end_cycle + STEP_LEN + 2)
				begin
					@(negedge clock);
					if (visible)
						ended = ({score_tens, score_ones} != last_score) || (game_over && !last_over);
					else
						ended = (cycle_count == end_cycle + STEP_LEN);
				end
				if (!ended)
				begin
					other_errors++;
					broken = 1'b1;
					$display("no end of step was seen within %0d cycles at %0t", STEP_LEN + 2, $time);
				end
				else
				begin
					check_value("playing", playing, !want.hit);
					check_value("game_over", game_over, want.hit);
					check_value("player_col", player_col, want.col);
					check_value("player_row", player_row, want.row);
					check_value("score_tens", score_tens, want.tens);
					check_value("score_ones", score_ones, want.ones);
					check_value("cell_map", cell_map, map_of(want));
				end
				last_score = {score_tens, score_ones};
				last_over = game_over;
				end_cycle = cycle_count;
				steps_checked++;
			end
		end
	end

	initial
	begin : watchdog
		wait (cycle_count >= TIMEOUT_CYCLES);
		other_errors++;
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_summary();
		$finish;
	end

	initial
	begin : run_tests
		go = 1'b0;
		left = 1'b0;
		right = 1'b0;
		up = 1'b0;
		down = 1'b0;
		model = '0;
		model.lfsr = game_pkg::LANE_SEED;
		wait (reset === 1'b1);
		@(negedge clock);
		check_value("playing after reset", playing, 0);
		check_value("game_over after reset", game_over, 0);
		check_value("score after reset", {score_tens, score_ones}, 0);
		check_value("cell_map after reset", cell_map, 0);
		check_value("player_col after reset", player_col, game_pkg::PLAYER_START_COL);
		check_value("player_row after reset", player_row, game_pkg::PLAYER_START_ROW);
		// random moves, then the player stands still until a block lands on it
		for (int g = 0; g < RANDOM_GAMES && !broken; g++)
		begin
			start_game();
			play_game(1'b0, RANDOM_STEPS);
		end
		if (!broken)
		begin
			start_game();
			play_game(1'b1, DODGE_STEPS);
			check_value("saturated score", {score_tens, score_ones}, 8'h99);
		end
		print_summary();
		$finish;
	end

endmodule

/* sources.f */
source/game_pkg.sv
source/step_timer.sv
source/game_fsm.sv
source/lane_random.sv
source/player_cell.sv
source/block_field.sv
source/dodge_top.sv
dv/tb_clock.sv
dv/dodge_tb.sv
